/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  // Architectural machine CSR addresses
  localparam logic [11:0] csr_addr_mstatus  = 12'h300;
  localparam logic [11:0] csr_addr_mie      = 12'h304;
  localparam logic [11:0] csr_addr_mtvec    = 12'h305;
  localparam logic [11:0] csr_addr_mscratch = 12'h340;
  localparam logic [11:0] csr_addr_mepc     = 12'h341;
  localparam logic [11:0] csr_addr_mcause   = 12'h342;
  localparam logic [11:0] csr_addr_mip      = 12'h344;

  // Slots inside the CSR array, mcause sits at 0 so unknown addresses land there
  localparam logic [2:0] idx_mcause   = 3'd0;
  localparam logic [2:0] idx_mtvec    = 3'd1;
  localparam logic [2:0] idx_mscratch = 3'd2;
  localparam logic [2:0] idx_mstatus  = 3'd3;
  localparam logic [2:0] idx_mepc     = 3'd4;
  localparam logic [2:0] idx_mip      = 3'd5;
  localparam logic [2:0] idx_mie      = 3'd6;
  localparam int         csr_count    = 7;

  localparam int mstatus_mie_bit  = 3;   // Global machine interrupt enable
  localparam int mstatus_mpie_bit = 7;   // Enable stacked on trap entry
  localparam int mip_msi_bit      = 3;   // Software interrupt pending/enable
  localparam int mip_mti_bit      = 7;   // Timer interrupt pending/enable
  localparam int mip_mei_bit      = 11;  // External interrupt pending/enable

  // Encoding follows funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    csr_rw  = 3'd1,
    csr_rs  = 3'd2,
    csr_rc  = 3'd3,
    csr_rwi = 3'd5,
    csr_rsi = 3'd6,
    csr_rci = 3'd7
  } csr_op_e;

  localparam logic [4:0] cause_msi     = 5'd3;   // Machine software interrupt
  localparam logic [4:0] cause_mti     = 5'd7;   // Machine timer interrupt
  localparam logic [4:0] cause_mei     = 5'd11;  // Machine external interrupt
  localparam logic [4:0] cause_ecall_m = 5'd11;  // Environment call from M-mode

  // Byte offsets of the timer registers from the block base
  localparam logic [31:0] tmr_off_mtime_lo    = 32'h0;
  localparam logic [31:0] tmr_off_mtime_hi    = 32'h4;
  localparam logic [31:0] tmr_off_mtimecmp_lo = 32'h8;
  localparam logic [31:0] tmr_off_mtimecmp_hi = 32'hC;
  localparam logic [31:0] tmr_off_msip        = 32'h10;

endpackage

`default_nettype wire

/* rtl/csr_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_alu (
  input  wire logic             csr_valid,    // Instruction is a Zicsr op
  input  wire logic             instr_valid,  // Instruction retires this cycle
  input  wire csr_pkg::csr_op_e csr_op,       // funct3 of the instruction
  input  wire logic [4:0]       rs1_idx,      // rs1 field, also the uimm field
  input  wire logic [31:0]      rs1_value,    // Register operand
  input  wire logic [31:0]      csr_old,      // Current CSR contents
  output logic      [31:0]      csr_in,       // Value to store
  output logic                  csr_en        // Store strobe
);

  logic [31:0] operand;   // Register or zero-extended immediate
  logic        op_write;  // Op would modify the CSR

  always_comb begin
    if (csr_op[2]) begin
      operand = {27'b0, rs1_idx};  // Immediate forms carry uimm in the rs1 field
    end else begin
      operand = rs1_value;
    end
  end

  always_comb begin
    csr_in   = csr_old;  // Default keeps the old value
    op_write = 1'b0;
    case (csr_op)
      csr_pkg::csr_rw, csr_pkg::csr_rwi: begin
        csr_in   = operand;            // Plain swap always writes
        op_write = 1'b1;
      end
      csr_pkg::csr_rs, csr_pkg::csr_rsi: begin
        csr_in   = csr_old | operand;  // Set the selected bits
        op_write = (rs1_idx != 5'd0);  // x0 or zero uimm is a pure read
      end
      csr_pkg::csr_rc, csr_pkg::csr_rci: begin
        csr_in   = csr_old & ~operand; // Clear the selected bits
        op_write = (rs1_idx != 5'd0);
      end
      default: begin
        csr_in   = csr_old;            // Reserved funct3 never writes
        op_write = 1'b0;
      end
    endcase
  end

  assign csr_en = instr_valid & csr_valid & op_write;  // Only retiring CSR ops store

endmodule

`default_nettype wire

/* rtl/csr_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_reg (
  input  wire logic        clk,
  input  wire logic        reset_n,
  input  wire logic [31:0] csr_in,      // Software write data from the ALU
  input  wire logic [31:0] mip_in,      // Raw pending lines, sampled every cycle
  input  wire logic [11:0] offset,      // Architectural CSR address
  input  wire logic        csr_en,      // Software write strobe
  input  wire logic        int_action,  // Trap entry this cycle
  input  wire logic        ret_action,  // mret retires this cycle
  input  wire logic        hw_int,      // Trap is an interrupt, not ecall
  input  wire logic [4:0]  int_code,    // Cause code of the trap
  input  wire logic [31:0] current_pc,  // PC of the retiring instruction
  output logic      [31:0] mcause,
  output logic      [31:0] csr_out,     // Old value for rd
  output logic      [31:0] mepc,
  output logic      [31:0] mie,
  output logic      [31:0] mip,
  output logic      [31:0] mtvec,
  output logic             MIE          // Global enable from mstatus
);

  logic [31:0] csr_mem [csr_pkg::csr_count];  // The seven machine CSR words
  logic [2:0]  idx;                           // Array slot of the addressed CSR
  logic        addr_hit;                      // Address names an implemented CSR

  // Address translation, unknown addresses read the mcause slot
  always_comb begin
    addr_hit = 1'b1;
    case (offset)
      csr_pkg::csr_addr_mie:      idx = csr_pkg::idx_mie;
      csr_pkg::csr_addr_mip:      idx = csr_pkg::idx_mip;
      csr_pkg::csr_addr_mepc:     idx = csr_pkg::idx_mepc;
      csr_pkg::csr_addr_mstatus:  idx = csr_pkg::idx_mstatus;
      csr_pkg::csr_addr_mscratch: idx = csr_pkg::idx_mscratch;
      csr_pkg::csr_addr_mtvec:    idx = csr_pkg::idx_mtvec;
      csr_pkg::csr_addr_mcause:   idx = csr_pkg::idx_mcause;
      default: begin
        idx      = csr_pkg::idx_mcause;  // Reads return mcause
        addr_hit = 1'b0;                 // Writes are dropped
      end
    endcase
  end

  assign csr_out = csr_mem[idx];  // Combinational read in the address cycle
  assign mcause  = csr_mem[csr_pkg::idx_mcause];
  assign mepc    = csr_mem[csr_pkg::idx_mepc];
  assign mie     = csr_mem[csr_pkg::idx_mie];
  assign mip     = csr_mem[csr_pkg::idx_mip];
  assign mtvec   = csr_mem[csr_pkg::idx_mtvec];
  assign MIE     = csr_mem[csr_pkg::idx_mstatus][csr_pkg::mstatus_mie_bit];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < csr_pkg::csr_count; i++) begin
        csr_mem[i] <= 32'b0;  // All CSRs start cleared
      end
    end else begin
      if (int_action) begin
        // Trap entry stacks the enable and disables further interrupts
        csr_mem[csr_pkg::idx_mstatus][csr_pkg::mstatus_mpie_bit] <=
          csr_mem[csr_pkg::idx_mstatus][csr_pkg::mstatus_mie_bit];
        csr_mem[csr_pkg::idx_mstatus][csr_pkg::mstatus_mie_bit] <= 1'b0;
        // Interrupts resume at the same pc, ecall resumes after it
        csr_mem[csr_pkg::idx_mepc]   <= hw_int ? current_pc : current_pc + 32'd4;
        csr_mem[csr_pkg::idx_mcause] <= {hw_int, 26'b0, int_code};  // Bit 31 flags interrupts
      end else if (ret_action) begin
        // mret restores the enable and clears the stacked copy
        csr_mem[csr_pkg::idx_mstatus][csr_pkg::mstatus_mie_bit] <=
          csr_mem[csr_pkg::idx_mstatus][csr_pkg::mstatus_mpie_bit];
        csr_mem[csr_pkg::idx_mstatus][csr_pkg::mstatus_mpie_bit] <= 1'b0;
      end else if (csr_en && addr_hit) begin
        csr_mem[idx] <= csr_in;  // Software write has lowest priority
      end
      csr_mem[csr_pkg::idx_mip] <= mip_in;  // Pending bits follow the sources one cycle late
    end
  end

endmodule

`default_nettype wire

/* rtl/int_control.sv */
`timescale 1ns/1ns
`default_nettype none

module int_control (
  input  wire logic        instr_valid,  // Instruction retires this cycle
  input  wire logic        ecall,        // Retiring instruction is ecall
  input  wire logic        MIE,          // Global enable from mstatus
  input  wire logic [31:0] mie,          // Per-source enables
  input  wire logic [31:0] mip,          // Sampled pending bits
  input  wire logic [31:0] mtvec,        // Trap vector base and mode
  input  wire logic [31:0] mepc,         // Return address for mret
  input  wire logic        mret,         // Retiring instruction is mret
  output logic             int_action,   // Take a trap this cycle
  output logic             hw_int,       // Trap is an interrupt
  output logic      [4:0]  int_code,     // Cause code for mcause
  output logic             redirect,     // Fetch must jump
  output logic      [31:0] redirect_pc   // Jump target
);

  logic [31:0] pending;      // Enabled and pending sources
  logic        ext_pend;
  logic        sw_pend;
  logic        tmr_pend;
  logic [31:0] vec_base;     // mtvec with the mode bits removed
  logic [31:0] trap_target;  // Direct or vectored entry point

  assign pending  = mip & mie & {32{MIE}};  // Global enable gates every source
  assign ext_pend = pending[csr_pkg::mip_mei_bit];
  assign sw_pend  = pending[csr_pkg::mip_msi_bit];
  assign tmr_pend = pending[csr_pkg::mip_mti_bit];

  assign hw_int     = ext_pend | sw_pend | tmr_pend;  // An interrupt beats ecall
  assign int_action = instr_valid & (hw_int | ecall);

  // Fixed priority external, then software, then timer
  always_comb begin
    if (ext_pend) begin
      int_code = csr_pkg::cause_mei;
    end else if (sw_pend) begin
      int_code = csr_pkg::cause_msi;
    end else if (tmr_pend) begin
      int_code = csr_pkg::cause_mti;
    end else begin
      int_code = csr_pkg::cause_ecall_m;  // Only ecall is left
    end
  end

  assign vec_base = {mtvec[31:2], 2'b00};

  always_comb begin
    if (mtvec[1:0] == 2'd1 && hw_int) begin
      trap_target = vec_base + {25'b0, int_code, 2'b00};  // Vectored mode uses base + 4*cause
    end else begin
      trap_target = vec_base;  // Direct mode and all exceptions
    end
  end

  assign redirect = int_action | (instr_valid & mret);

  always_comb begin
    if (int_action) begin
      redirect_pc = trap_target;  // Trap entry wins over mret
    end else begin
      redirect_pc = mepc;
    end
  end

endmodule

`default_nettype wire

/* rtl/machine_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module machine_timer #(
  parameter logic [31:0] TIMER_BASE = 32'h0200_0000  // Word-aligned block base
) (
  input  wire logic        clk,
  input  wire logic        reset_n,
  input  wire logic        bus_sel,    // Bus access this cycle
  input  wire logic        bus_we,     // Access is a write
  input  wire logic [31:0] bus_addr,   // Byte address
  input  wire logic [31:0] bus_wdata,  // Write data
  output logic      [31:0] bus_rdata,  // Read data, combinational
  output logic             timer_irq,  // mtime has reached mtimecmp
  output logic             soft_irq    // msip bit 0
);

  localparam logic [31:0] addr_mtime_lo    = TIMER_BASE + csr_pkg::tmr_off_mtime_lo;
  localparam logic [31:0] addr_mtime_hi    = TIMER_BASE + csr_pkg::tmr_off_mtime_hi;
  localparam logic [31:0] addr_mtimecmp_lo = TIMER_BASE + csr_pkg::tmr_off_mtimecmp_lo;
  localparam logic [31:0] addr_mtimecmp_hi = TIMER_BASE + csr_pkg::tmr_off_mtimecmp_hi;
  localparam logic [31:0] addr_msip        = TIMER_BASE + csr_pkg::tmr_off_msip;

  logic [63:0] mtime;     // Free-running counter
  logic [63:0] mtimecmp;  // Compare value
  logic        msip;      // Software interrupt request
  logic        wr;        // Write strobe for this cycle

  assign wr = bus_sel & bus_we;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtime    <= 64'b0;
      mtimecmp <= '1;     // No timer interrupt until software programs it
      msip     <= 1'b0;
    end else begin
      // A word write replaces that half, otherwise the counter advances
      if (wr && bus_addr == addr_mtime_lo) begin
        mtime <= {mtime[63:32], bus_wdata};
      end else if (wr && bus_addr == addr_mtime_hi) begin
        mtime <= {bus_wdata, mtime[31:0]};
      end else begin
        mtime <= mtime + 64'd1;
      end
      if (wr && bus_addr == addr_mtimecmp_lo) begin
        mtimecmp[31:0] <= bus_wdata;
      end
      if (wr && bus_addr == addr_mtimecmp_hi) begin
        mtimecmp[63:32] <= bus_wdata;
      end
      if (wr && bus_addr == addr_msip) begin
        msip <= bus_wdata[0];  // Only bit 0 is implemented
      end
    end
  end

  // Read mux, unmapped or idle accesses return zero
  always_comb begin
    bus_rdata = 32'b0;
    if (bus_sel) begin
      case (bus_addr)
        addr_mtime_lo:    bus_rdata = mtime[31:0];
        addr_mtime_hi:    bus_rdata = mtime[63:32];
        addr_mtimecmp_lo: bus_rdata = mtimecmp[31:0];
        addr_mtimecmp_hi: bus_rdata = mtimecmp[63:32];
        addr_msip:        bus_rdata = {31'b0, msip};
        default:          bus_rdata = 32'b0;
      endcase
    end
  end

  assign timer_irq = (mtime >= mtimecmp);  // Level stays up until mtimecmp moves
  assign soft_irq  = msip;

endmodule

`default_nettype wire

/* rtl/trap_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module trap_unit_top #(
  parameter logic [31:0] TIMER_BASE = 32'h0200_0000  // Base address of the timer block
) (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire logic             instr_valid,  // Instruction at current_pc retires
  input  wire logic [31:0]      current_pc,
  input  wire logic             csr_valid,    // Retiring instruction is a CSR op
  input  wire csr_pkg::csr_op_e csr_op,
  input  wire logic [11:0]      csr_addr,
  input  wire logic [4:0]       rs1_idx,
  input  wire logic [31:0]      rs1_value,
  input  wire logic             mret,
  input  wire logic             ecall,
  input  wire logic             ext_irq,      // External interrupt level
  input  wire logic             bus_sel,
  input  wire logic             bus_we,
  input  wire logic [31:0]      bus_addr,
  input  wire logic [31:0]      bus_wdata,
  output logic      [31:0]      rd_value,     // Old CSR value
  output logic      [31:0]      bus_rdata,
  output logic                  redirect,
  output logic      [31:0]      redirect_pc
);

  logic [31:0] csr_in;
  logic        csr_en;
  logic [31:0] mip_in;      // Pending lines in mip bit order
  logic        int_action;
  logic        hw_int;
  logic [4:0]  int_code;
  logic        ret_action;  // mret qualified by retirement
  logic [31:0] mepc;
  logic [31:0] mie;
  logic [31:0] mip;
  logic [31:0] mtvec;
  logic        glob_mie;
  logic        timer_irq;
  logic        soft_irq;

  // Sources land on their architectural mip positions
  always_comb begin
    mip_in                       = 32'b0;
    mip_in[csr_pkg::mip_mei_bit] = ext_irq;
    mip_in[csr_pkg::mip_mti_bit] = timer_irq;
    mip_in[csr_pkg::mip_msi_bit] = soft_irq;
  end

  assign ret_action = mret & instr_valid;

  csr_alu u_csr_alu (
    .csr_valid   (csr_valid),
    .instr_valid (instr_valid),
    .csr_op      (csr_op),
    .rs1_idx     (rs1_idx),
    .rs1_value   (rs1_value),
    .csr_old     (rd_value),
    .csr_in      (csr_in),
    .csr_en      (csr_en)
  );

  csr_reg u_csr_reg (
    .clk        (clk),
    .reset_n    (reset_n),
    .csr_in     (csr_in),
    .mip_in     (mip_in),
    .offset     (csr_addr),
    .csr_en     (csr_en),
    .int_action (int_action),
    .ret_action (ret_action),
    .hw_int     (hw_int),
    .int_code   (int_code),
    .current_pc (current_pc),
    .mcause     (),
    .csr_out    (rd_value),
    .mepc       (mepc),
    .mie        (mie),
    .mip        (mip),
    .mtvec      (mtvec),
    .MIE        (glob_mie)
  );

  int_control u_int_control (
    .instr_valid (instr_valid),
    .ecall       (ecall),
    .MIE         (glob_mie),
    .mie         (mie),
    .mip         (mip),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mret        (mret),
    .int_action  (int_action),
    .hw_int      (hw_int),
    .int_code    (int_code),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  machine_timer #(
    .TIMER_BASE (TIMER_BASE)
  ) u_machine_timer (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_sel   (bus_sel),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .timer_irq (timer_irq),
    .soft_irq  (soft_irq)
  );

endmodule

`default_nettype wire

/* verification/trap_unit_tasks.svh */
`ifndef TRAP_UNIT_TASKS_SVH
`define TRAP_UNIT_TASKS_SVH

  task automatic expect_equal(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // One retiring Zicsr instruction with the old value sampled in its own cycle
  task automatic csr_exec(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                          input logic [4:0] src, input logic [31:0] value,
                          output logic [31:0] old);
    @(negedge clk);
    instr_valid = 1'b1;
    csr_valid   = 1'b1;
    csr_op      = op;
    csr_addr    = addr;
    rs1_idx     = src;    // Also the uimm field for the immediate forms
    rs1_value   = value;
    #1 old = rd_value;
    expect_equal("redirect during CSR op", {31'b0, redirect}, 32'h0);  // Interrupts are off here
    @(negedge clk);
    instr_valid = 1'b0;
    csr_valid   = 1'b0;
  endtask

  task automatic csr_peek(input logic [11:0] addr, output logic [31:0] value);
    @(negedge clk);
    csr_addr = addr;      // Nothing retires so the read leaves the CSRs alone
    #1 value = rd_value;
  endtask

  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    bus_sel   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = wdata;
    #1 rdata = bus_rdata;  // Read data is combinational
    @(negedge clk);
    bus_sel = 1'b0;
    bus_we  = 1'b0;
  endtask

  // Hold one instruction retiring until the DUT redirects
  task automatic retire_until_redirect(input logic [31:0] pc, input logic is_ecall,
                                       input logic is_mret, output logic [31:0] target);
    int cycles;
    cycles = 0;
    @(negedge clk);
    instr_valid = 1'b1;
    current_pc  = pc;
    ecall       = is_ecall;
    mret        = is_mret;
    #1;
    while (!redirect) begin
      if (cycles == wait_limit) begin
        $display("Timeout at %0t ns: no redirect for pc %h", $time, pc);
        abort_run();
      end
      @(negedge clk);
      #1;
      cycles++;
    end
    target = redirect_pc;  // The trap or return takes effect at the coming edge
    @(negedge clk);
    instr_valid = 1'b0;
    ecall       = 1'b0;
    mret        = 1'b0;
  endtask

  task automatic scratch_op(input csr_pkg::csr_op_e op, input logic [4:0] src,
                            input logic [31:0] value, input logic [31:0] next);
    logic [31:0] old;
    csr_exec(op, csr_pkg::csr_addr_mscratch, src, value, old);
    expect_equal("mscratch old value", old, mscratch_model);
    mscratch_model = next;
  endtask

  task automatic csr_op_sequence();
    logic [31:0] data;
    logic [31:0] now;
    data = $random(seed);
    scratch_op(csr_pkg::csr_rw, 5'd1, data, data);
    scratch_op(csr_pkg::csr_rs, 5'd2, 32'h0000_f0f0, mscratch_model | 32'h0000_f0f0);
    scratch_op(csr_pkg::csr_rc, 5'd3, 32'h0000_00ff, mscratch_model & ~32'h0000_00ff);
    scratch_op(csr_pkg::csr_rsi, 5'd9, 32'hffff_ffff, mscratch_model | 32'h0000_0009);
    scratch_op(csr_pkg::csr_rci, 5'd1, 32'hffff_ffff, mscratch_model & ~32'h0000_0001);
    scratch_op(csr_pkg::csr_rs, 5'd0, 32'hffff_ffff, mscratch_model);  // Plain poll
    scratch_op(csr_pkg::csr_rwi, 5'd22, 32'hffff_ffff, 32'h0000_0016);
    csr_peek(csr_pkg::csr_addr_mscratch, now);
    expect_equal("mscratch final", now, mscratch_model);
  endtask

  task automatic timer_bus_access();
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] value;
    bus_access(1'b1, addr_mtimecmp_lo, 32'h1234_5678, value);
    bus_access(1'b1, addr_mtimecmp_hi, 32'ha5a5_0001, value);
    bus_access(1'b1, addr_msip, 32'h0000_0001, value);
    bus_access(1'b0, addr_mtimecmp_lo, 32'h0, value);
    expect_equal("mtimecmp low", value, 32'h1234_5678);
    bus_access(1'b0, addr_mtimecmp_hi, 32'h0, value);
    expect_equal("mtimecmp high", value, 32'ha5a5_0001);
    bus_access(1'b0, addr_msip, 32'h0, value);
    expect_equal("msip", value, 32'h0000_0001);
    bus_access(1'b1, addr_msip, 32'h0, value);  // Drop the software request again
    bus_access(1'b0, addr_mtime_lo, 32'h0, first);
    bus_access(1'b0, addr_mtime_lo, 32'h0, second);
    assert (second > first) else begin
      $display("** Error at %0t ns: mtime went from %h to %h", $time, first, second);
      abort_run();
    end
    bus_access(1'b1, timer_base + 32'h14, 32'hffff_ffff, value);
    bus_access(1'b0, timer_base + 32'h14, 32'h0, value);
    expect_equal("unmapped timer word", value, 32'h0);
  endtask

  task automatic timer_irq_direct();
    logic [31:0] old;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] target;
    logic [31:0] value;
    csr_exec(csr_pkg::csr_rw, csr_pkg::csr_addr_mtvec, 5'd1, 32'h0000_0100, old);
    csr_exec(csr_pkg::csr_rw, csr_pkg::csr_addr_mie, 5'd1, 32'h0000_0080, old);
    bus_access(1'b0, addr_mtime_hi, 32'h0, hi);
    bus_access(1'b0, addr_mtime_lo, 32'h0, lo);
    bus_access(1'b1, addr_mtimecmp_lo, lo + 32'd40, value);  // Low half first keeps it quiet
    bus_access(1'b1, addr_mtimecmp_hi, hi, value);
    csr_exec(csr_pkg::csr_rs, csr_pkg::csr_addr_mstatus, 5'd1, 32'h0000_0008, old);
    retire_until_redirect(32'h0000_4000, 1'b0, 1'b0, target);
    expect_equal("timer trap target", target, 32'h0000_0100);
    csr_peek(csr_pkg::csr_addr_mepc, value);
    expect_equal("mepc after timer trap", value, 32'h0000_4000);
    csr_peek(csr_pkg::csr_addr_mcause, value);
    expect_equal("mcause after timer trap", value, 32'h8000_0007);
    csr_peek(csr_pkg::csr_addr_mstatus, value);
    expect_equal("mstatus MPIE and MIE", value & 32'h88, 32'h0000_0080);
    bus_access(1'b1, addr_mtimecmp_hi, 32'hffff_ffff, value);  // Timer far in the future
  endtask

  task automatic vectored_priority();
    logic [31:0] old;
    logic [31:0] target;
    logic [31:0] value;
    csr_exec(csr_pkg::csr_rw, csr_pkg::csr_addr_mtvec, 5'd1, 32'h0000_0201, old);
    csr_exec(csr_pkg::csr_rw, csr_pkg::csr_addr_mie, 5'd1, 32'h0000_0808, old);
    @(negedge clk);
    ext_irq = 1'b1;
    bus_access(1'b1, addr_msip, 32'h0000_0001, value);
    csr_exec(csr_pkg::csr_rs, csr_pkg::csr_addr_mstatus, 5'd1, 32'h0000_0008, old);
    retire_until_redirect(32'h0000_5000, 1'b0, 1'b0, target);
    expect_equal("external vector target", target, 32'h0000_022c);  // 0x200 + 4 * 11
    csr_peek(csr_pkg::csr_addr_mcause, value);
    expect_equal("mcause after external trap", value, 32'h8000_000b);
    @(negedge clk);
    ext_irq = 1'b0;
    csr_exec(csr_pkg::csr_rs, csr_pkg::csr_addr_mstatus, 5'd1, 32'h0000_0008, old);
    retire_until_redirect(32'h0000_5100, 1'b0, 1'b0, target);
    expect_equal("software vector target", target, 32'h0000_020c);  // 0x200 + 4 * 3
    csr_peek(csr_pkg::csr_addr_mcause, value);
    expect_equal("mcause after software trap", value, 32'h8000_0003);
    bus_access(1'b1, addr_msip, 32'h0, value);
  endtask

  task automatic ecall_entry();
    logic [31:0] old;
    logic [31:0] target;
    logic [31:0] value;
    csr_exec(csr_pkg::csr_rw, csr_pkg::csr_addr_mstatus, 5'd1, 32'h0, old);
    retire_until_redirect(32'h0000_6000, 1'b1, 1'b0, target);
    expect_equal("ecall target", target, 32'h0000_0200);  // Exceptions ignore vectoring
    csr_peek(csr_pkg::csr_addr_mepc, value);
    expect_equal("mepc after ecall", value, 32'h0000_6004);
    csr_peek(csr_pkg::csr_addr_mcause, value);
    expect_equal("mcause after ecall", value, 32'h0000_000b);
  endtask

  task automatic mret_return();
    logic [31:0] old;
    logic [31:0] target;
    logic [31:0] value;
    csr_exec(csr_pkg::csr_rw, csr_pkg::csr_addr_mie, 5'd1, 32'h0, old);
    csr_exec(csr_pkg::csr_rs, csr_pkg::csr_addr_mstatus, 5'd1, 32'h0000_0008, old);
    retire_until_redirect(32'h0000_7000, 1'b1, 1'b0, target);
    csr_peek(csr_pkg::csr_addr_mstatus, value);
    expect_equal("mstatus inside handler", value & 32'h88, 32'h0000_0080);
    retire_until_redirect(32'h0000_0200, 1'b0, 1'b1, target);
    expect_equal("mret target", target, 32'h0000_7004);
    csr_peek(csr_pkg::csr_addr_mstatus, value);
    expect_equal("mstatus after mret", value & 32'h88, 32'h0000_0008);
  endtask

`endif

/* verification/trap_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module trap_unit_tb;

  localparam logic [31:0] timer_base = 32'h0200_0000;  // Timer block base handed to the DUT
  localparam int          wait_limit = 400;            // Cycles a redirect wait may take

  localparam logic [31:0] addr_mtime_lo    = timer_base + csr_pkg::tmr_off_mtime_lo;
  localparam logic [31:0] addr_mtime_hi    = timer_base + csr_pkg::tmr_off_mtime_hi;
  localparam logic [31:0] addr_mtimecmp_lo = timer_base + csr_pkg::tmr_off_mtimecmp_lo;
  localparam logic [31:0] addr_mtimecmp_hi = timer_base + csr_pkg::tmr_off_mtimecmp_hi;
  localparam logic [31:0] addr_msip        = timer_base + csr_pkg::tmr_off_msip;

  logic             clk;
  logic             reset_n;
  logic             instr_valid;   // Retire strobe toward the DUT
  logic [31:0]      current_pc;
  logic             csr_valid;
  csr_pkg::csr_op_e csr_op;
  logic [11:0]      csr_addr;
  logic [4:0]       rs1_idx;
  logic [31:0]      rs1_value;
  logic             mret;
  logic             ecall;
  logic             ext_irq;       // External interrupt line
  logic             bus_sel;
  logic             bus_we;
  logic [31:0]      bus_addr;
  logic [31:0]      bus_wdata;
  logic [31:0]      rd_value;
  logic [31:0]      bus_rdata;
  logic             redirect;
  logic [31:0]      redirect_pc;

  int          seed = 32'h262b3d39;  // Fixed seed for the random CSR data
  logic [31:0] mscratch_model;       // Expected mscratch contents

  trap_unit_top #(.TIMER_BASE(timer_base)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Every failing check or timeout ends here
  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  `include "trap_unit_tasks.svh"

  initial begin
    reset_n        = 1'b0;
    instr_valid    = 1'b0;
    current_pc     = 32'h0;
    csr_valid      = 1'b0;
    csr_op         = csr_pkg::csr_rw;
    csr_addr       = 12'h0;
    rs1_idx        = 5'd0;
    rs1_value      = 32'h0;
    mret           = 1'b0;
    ecall          = 1'b0;
    ext_irq        = 1'b0;
    bus_sel        = 1'b0;
    bus_we         = 1'b0;
    bus_addr       = 32'h0;
    bus_wdata      = 32'h0;
    mscratch_model = 32'h0;                 // All CSRs come out of reset cleared
    repeat (3) @(posedge clk);              // Reset held for three edges
    @(negedge clk);
    reset_n = 1'b1;
    csr_op_sequence();
    timer_bus_access();
    timer_irq_direct();
    vectored_priority();
    ecall_entry();
    mret_return();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+verification
rtl/csr_pkg.sv
rtl/csr_alu.sv
rtl/csr_reg.sv
rtl/int_control.sv
rtl/machine_timer.sv
rtl/trap_unit_top.sv
verification/trap_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the trap unit testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module trap_unit_tb \
  -Mdir obj_dir -o trap_unit_sim

status=0
./obj_dir/trap_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
exit 0
